//--- Bender.yml
package:
  name: mgmt_node

sources:
  - design/mgmt_pkg.sv
  - design/mgmt_if.sv
  - design/mgmt_fsm.sv
  - design/mgmt_hop_counter.sv
  - design/mgmt_resp_fifo.sv
  - design/mgmt_word_builder.sv
  - design/mgmt_node.sv
  - target: test
    files:
      - bench/mgmt_tb_clk.sv
      - bench/mgmt_sva.sv
      - bench/mgmt_tb.sv

//--- all.f
design/mgmt_pkg.sv
design/mgmt_if.sv
design/mgmt_fsm.sv
design/mgmt_hop_counter.sv
design/mgmt_resp_fifo.sv
design/mgmt_word_builder.sv
design/mgmt_node.sv
bench/mgmt_tb_clk.sv
bench/mgmt_sva.sv
bench/mgmt_tb.sv

//--- bench/mgmt_sva.sv
/* Concurrent assertions on the management node top level.
   Attached to every mgmt_node instance by the bind at the end. */
`timescale 1ns/1ps

module mgmt_sva (
  input logic            clk,
  input logic            rst,
  input mgmt_pkg::word_t i_out_data,
  input logic            i_out_last,
  input logic            i_out_valid,
  input logic            i_out_ready,
  input logic            i_cp_wr,
  input logic            i_cp_rd
);

  // Failures seen so far, polled by the testbench
  int unsigned assert_fails = 0;

  // Control port ------------------
  cp_one_kind: assert property (@(posedge clk) disable iff (rst) !(i_cp_wr && i_cp_rd))
    else begin
      $error("Write and read request in the same cycle");
      assert_fails++;
    end

  // Requests are single-cycle strobes
  cp_wr_pulse: assert property (@(posedge clk) disable iff (rst) i_cp_wr |=> !i_cp_wr)
    else begin
      $error("Write request longer than one cycle");
      assert_fails++;
    end

  cp_rd_pulse: assert property (@(posedge clk) disable iff (rst) i_cp_rd |=> !i_cp_rd)
    else begin
      $error("Read request longer than one cycle");
      assert_fails++;
    end

  // Output stream -----------------
  // Stalled beat keeps valid, data and last
  out_hold: assert property (@(posedge clk) disable iff (rst)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data) && $stable(i_out_last))
    else begin
      $error("Output beat changed while stalled");
      assert_fails++;
    end

  out_quiet_in_reset: assert property (@(posedge clk) rst |-> !i_out_valid)
    else begin
      $error("Output valid during reset");
      assert_fails++;
    end

endmodule

bind mgmt_node mgmt_sva sva_i (
  .clk         (clk),
  .rst         (rst),
  .i_out_data  (o_tdata),
  .i_out_last  (o_tlast),
  .i_out_valid (o_tvalid),
  .i_out_ready (i_tready_out),
  .i_cp_wr     (o_cp_wr),
  .i_cp_rd     (o_cp_rd)
);

//--- bench/mgmt_tb.sv
/* Testbench for the management node. Sends directed and random management
   packets, answers the control port and checks every output beat and request. */
`timescale 1ns/1ps

module mgmt_tb;
  import mgmt_pkg::*;

  typedef word_t       word_q_t[$];
  typedef cp_data_t    data_q_t[$];
  typedef opcode_t     op_q_t[$];
  // Expected request as {is_read, addr, data}
  typedef logic [48:0] req_t;
  typedef req_t        req_q_t[$];

  localparam int RESET_CYCLES   = 16;
  localparam int RANDOM_PKTS    = 50;
  localparam int NUM_PKTS       = 7 + RANDOM_PKTS;
  localparam int CYCLES_PER_PKT = 200;
  localparam opcode_t VALID_OPS [6] = '{OP_NOP, OP_INFO_REQ, OP_INFO_RESP,
                                        OP_CFG_WR_REQ, OP_CFG_RD_REQ, OP_CFG_RD_RESP};

  logic     clk;
  logic     rst;
  word_t    i_tdata;
  logic     i_tlast;
  logic     i_tvalid;
  logic     o_tready_in;
  word_t    o_tdata;
  logic     o_tlast;
  logic     o_tvalid;
  logic     i_tready_out;
  logic     o_cp_wr;
  logic     o_cp_rd;
  cp_addr_t o_cp_addr;
  cp_data_t o_cp_data;
  logic     i_cp_ack;
  cp_data_t i_cp_rdata;

  // One generator state per process
  logic [31:0] stim_rng;
  logic [31:0] bp_rng;
  logic [31:0] ack_rng;
  logic        bp_on;
  word_q_t     exp_q;
  req_q_t      exp_req_q;
  data_q_t     rdata_q;
  int          fail_count;
  int          beat_count;

  mgmt_tb_clk clk_gen_i (.o_clk(clk));

  mgmt_node dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready_in  (o_tready_in),
    .o_tdata      (o_tdata),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .i_tready_out (i_tready_out),
    .o_cp_wr      (o_cp_wr),
    .o_cp_rd      (o_cp_rd),
    .o_cp_addr    (o_cp_addr),
    .o_cp_data    (o_cp_data),
    .i_cp_ack     (i_cp_ack),
    .i_cp_rdata   (i_cp_rdata)
  );

  // ------------------------------
  // Random numbers
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  function automatic word_t rand64();
    word_t w;
    w[63:32] = rand32();
    w[31:0]  = rand32();
    return w;
  endfunction

  // ------------------------------
  // Failure handling
  task automatic abort_run();
    fail_count++;
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic report_problem(input string why);
    $display("ERROR: %s", why);
    abort_run();
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%016h expected 0x%016h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input cp_addr_t got, input cp_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input cp_data_t got, input cp_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------
  // Packet generation
  function automatic word_q_t make_packet(input int nmd, input int nhops, input op_q_t ops0);
    word_q_t pkt;
    word_t   w;
    int      nops;
    for (int k = 0; k < nmd; k++)
      pkt.push_back(rand64());
    w = rand64();
    w[25:16] = hops_t'(nhops);
    pkt.push_back(w);
    // Own hop, ops_pending counts down to 0
    for (int k = 0; k < ops0.size(); k++) begin
      w = rand64();
      w[15:8] = ops0[k];
      w[7:0]  = pending_t'(ops0.size() - 1 - k);
      pkt.push_back(w);
    end
    // Later hops carry one to three ops of any kind
    for (int h = 1; h < nhops; h++) begin
      nops = 1 + int'(rand32() % 3);
      for (int k = 0; k < nops; k++) begin
        w = rand64();
        w[7:0] = pending_t'(nops - 1 - k);
        pkt.push_back(w);
      end
    end
    // CHDR header, length in bytes includes itself
    w = rand64();
    w[36:32] = 5'(nmd);
    w[31:16] = len_t'(8 * (pkt.size() + 1));
    pkt.push_front(w);
    return pkt;
  endfunction

  // ------------------------------
  // Reference model
  // Control-port requests made by the own hop, up to an unknown opcode
  function automatic req_q_t build_requests(input word_q_t pkt);
    req_q_t reqs;
    word_t  w;
    int     idx;
    idx = 2 + int'(pkt[0][36:32]);
    if (pkt[idx - 1][25:16] < 10'd2)
      return reqs;
    do begin
      w = pkt[idx];
      idx++;
      if (w[15:8] == OP_CFG_WR_REQ || w[15:8] == OP_CFG_RD_REQ)
        reqs.push_back({w[15:8] == OP_CFG_RD_REQ, w[31:16], w[63:32]});
      else if (!(w[15:8] inside {OP_NOP, OP_INFO_REQ, OP_INFO_RESP, OP_CFG_RD_RESP}))
        return reqs;
    end while (w[7:0] != 8'd0);
    return reqs;
  endfunction

  // Output packet, empty when the packet is flushed
  function automatic word_q_t build_expected(input word_q_t pkt, input data_q_t rdata);
    word_q_t out;
    resp_t   resps[$];
    word_t   w;
    word_t   mgmt;
    int      idx;
    int      nmd;
    int      nops0;
    int      hop;
    int      rd_i;
    hops_t   nhops;
    len_t    len;
    nmd   = int'(pkt[0][36:32]);
    mgmt  = pkt[1 + nmd];
    nhops = mgmt[25:16];
    idx   = 2 + nmd;
    nops0 = 0;
    rd_i  = 0;
    if (nhops < 10'd2)
      return out;
    // Own hop executed and stripped
    do begin
      w = pkt[idx];
      idx++;
      nops0++;
      case (w[15:8])
        OP_CFG_RD_REQ: begin
          resps.push_back({rdata[rd_i], w[31:16], OP_CFG_RD_RESP});
          rd_i++;
        end
        OP_INFO_REQ: resps.push_back({NODE_INFO, OP_INFO_RESP});
        OP_NOP, OP_INFO_RESP, OP_CFG_WR_REQ, OP_CFG_RD_RESP: begin
        end
        default: return out;
      endcase
    end while (w[7:0] != 8'd0);
    // Headers, metadata and own ops leave, responses join
    len = pkt[0][31:16] - len_t'(8 * (2 + nmd + nops0)) + len_t'(8 * resps.size());
    out.push_back({pkt[0][63:37], 5'd0, len, pkt[0][15:0]});
    out.push_back({PROTOVER, CHDR_W_ENUM, 19'd0, nhops - 10'd1, mgmt[15:0]});
    // Middle hops as-is, last hop counts the responses
    hop = 1;
    while (idx < pkt.size()) begin
      w = pkt[idx];
      idx++;
      if (hop == int'(nhops) - 1)
        out.push_back({w[63:8], w[7:0] + pending_t'(resps.size())});
      else
        out.push_back(w);
      if (w[7:0] == 8'd0)
        hop++;
    end
    for (int k = 0; k < resps.size(); k++)
      out.push_back({resps[k][55:8], resps[k][7:0], pending_t'(resps.size() - 1 - k)});
    return out;
  endfunction

  // ------------------------------
  // Stimulus
  task automatic send_words(input word_q_t pkt);
    for (int k = 0; k < pkt.size(); k++) begin
      i_tdata  = pkt[k];
      i_tlast  = (k == pkt.size() - 1);
      i_tvalid = 1'b1;
      // Held until taken at the next edge
      do @(negedge clk); while (!o_tready_in);
      @(posedge clk);
      #1;
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic run_packet(input word_q_t pkt);
    word_q_t exp;
    req_q_t  reqs;
    data_q_t rdata;
    reqs = build_requests(pkt);
    // Read data the responder will return
    foreach (reqs[k]) begin
      if (reqs[k][48])
        rdata.push_back(rand32());
    end
    exp = build_expected(pkt, rdata);
    foreach (exp[k]) exp_q.push_back(exp[k]);
    foreach (reqs[k]) exp_req_q.push_back(reqs[k]);
    foreach (rdata[k]) rdata_q.push_back(rdata[k]);
    send_words(pkt);
    while (exp_q.size() != 0)
      @(posedge clk);
  endtask

  // Output ready, random while back-pressure is on
  initial begin
    forever begin
      @(posedge clk);
      #1;
      bp_rng = xorshift(bp_rng);
      i_tready_out = !bp_on || (bp_rng[1:0] != 2'b00);
    end
  end

  // ------------------------------
  // Control-port responder
  task automatic check_request();
    req_t req;
    if (exp_req_q.size() == 0) begin
      report_problem("control-port request while none was expected");
    end else begin
      req = exp_req_q.pop_front();
      if (req[48] !== o_cp_rd)
        report_problem("control-port request has the wrong direction");
      check_addr("o_cp_addr", o_cp_addr, req[47:32]);
      check_data("o_cp_data", o_cp_data, req[31:0]);
    end
  endtask

  // Ack 0 to 5 cycles after the strobe
  initial begin
    int   delay;
    logic is_rd;
    forever begin
      @(negedge clk);
      if (o_cp_wr || o_cp_rd) begin
        is_rd = o_cp_rd;
        check_request();
        ack_rng = xorshift(ack_rng);
        delay   = int'(ack_rng % 6);
        @(posedge clk);
        repeat (delay) @(posedge clk);
        #1;
        i_cp_ack = 1'b1;
        if (is_rd && rdata_q.size() != 0)
          i_cp_rdata = rdata_q.pop_front();
        @(posedge clk);
        #1;
        i_cp_ack = 1'b0;
      end
    end
  end

  // ------------------------------
  // Output compare, beat taken at the coming edge
  initial begin
    word_t exp_w;
    forever begin
      @(negedge clk);
      if (o_tvalid && i_tready_out) begin
        if (exp_q.size() == 0) begin
          report_problem("output beat while no packet was expected");
        end else begin
          exp_w = exp_q.pop_front();
          check_word("o_tdata", o_tdata, exp_w);
          check_last("o_tlast", o_tlast, exp_q.size() == 0);
          beat_count++;
        end
      end
    end
  end

  // Bound assertions
  always @(negedge clk) begin
    if (dut_i.sva_i.assert_fails != 0)
      report_problem("a bound assertion failed");
  end

  // Watchdog
  initial begin
    repeat (RESET_CYCLES + NUM_PKTS * CYCLES_PER_PKT) @(posedge clk);
    report_problem("watchdog timeout, the run did not finish in time");
  end

  // ------------------------------
  // Test sequence
  initial begin
    op_q_t ops;
    int    n;
    stim_rng     = 32'd99384;
    bp_rng       = 32'd99384 ^ 32'h5bd1e995;
    ack_rng      = 32'd99384 ^ 32'h9e3779b9;
    rst          = 1'b1;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_tready_out = 1'b1;
    i_cp_ack     = 1'b0;
    i_cp_rdata   = '0;
    bp_on        = 1'b0;
    fail_count   = 0;
    beat_count   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Single write, two hops
    ops = {OP_CFG_WR_REQ};
    run_packet(make_packet(0, 2, ops));
    // Single read, one response appended
    ops = {OP_CFG_RD_REQ};
    run_packet(make_packet(0, 2, ops));
    // Node info then read, two responses in order
    ops = {OP_INFO_REQ, OP_CFG_RD_REQ};
    run_packet(make_packet(0, 3, ops));

    // Metadata stripped, middle hop under back-pressure
    bp_on = 1'b1;
    ops = {OP_NOP};
    run_packet(make_packet(2, 3, ops));

    // Flushed packets, then a normal one
    ops = {OP_CFG_WR_REQ};
    run_packet(make_packet(0, 1, ops));
    ops = {8'hEE, OP_CFG_WR_REQ};
    run_packet(make_packet(0, 3, ops));
    ops = {OP_CFG_RD_REQ};
    run_packet(make_packet(1, 2, ops));

    // Random packets
    for (int p = 0; p < RANDOM_PKTS; p++) begin
      ops = {};
      n = 1 + int'(rand32() % 4);
      for (int k = 0; k < n; k++)
        ops.push_back(VALID_OPS[rand32() % 6]);
      run_packet(make_packet(int'(rand32() % 3), 2 + int'(rand32() % 3), ops));
    end

    if (exp_req_q.size() != 0 || rdata_q.size() != 0) begin
      $display("ERROR: expected control-port requests never arrived");
      fail_count++;
    end
    $display("%0d output beats checked", beat_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

//--- bench/mgmt_tb_clk.sv
/* Free-running testbench clock, 10 ns period, starts low. */
`timescale 1ns/1ps

module mgmt_tb_clk (
  output logic o_clk
);

  // Half period of 5 ns
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

endmodule

//--- design/mgmt_fsm.sv
/* Packet-parsing and operation FSM of the management node. Consumes the
   first hop, drives the control port and chooses each output word. */
`timescale 1ns/1ps

module mgmt_fsm (
  input  logic                 clk,
  input  logic                 rst,
  // CHDR input stream
  input  mgmt_pkg::word_t      i_tdata,
  input  logic                 i_tlast,
  input  logic                 i_tvalid,
  output logic                 o_tready_in,
  // CHDR output handshake
  output logic                 o_tvalid,
  input  logic                 i_tready_out,
  output mgmt_pkg::out_sel_t   o_sel,
  output logic                 o_cache_chdr,
  output logic                 o_cache_mgmt,
  output logic                 o_tlast_gen,
  mgmt_count_if.ctl            cnt,
  mgmt_resp_if.wr              resp,
  // Control port
  output logic                 o_cp_wr,
  output logic                 o_cp_rd,
  output mgmt_pkg::cp_addr_t   o_cp_addr,
  output mgmt_pkg::cp_data_t   o_cp_data,
  input  logic                 i_cp_ack,
  input  mgmt_pkg::cp_data_t   i_cp_rdata
);
  import mgmt_pkg::*;

  pkt_state_t state;
  logic [4:0] mdata_left;
  // Input packet already ended while the last hop was forwarded
  logic       in_done;
  opcode_t    op_code;
  pending_t   ops_pending;
  payload_t   op_payload;
  logic       in_acc;
  logic       out_acc;

  assign op_code     = get_opcode(i_tdata);
  assign ops_pending = get_ops_pending(i_tdata);
  assign op_payload  = get_payload(i_tdata);
  assign in_acc      = i_tvalid && o_tready_in;
  assign out_acc     = o_tvalid && i_tready_out;

  // State transitions ------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_CHDR_IN;
      mdata_left <= '0;
      in_done    <= 1'b0;
    end else begin
      case (state)
        // Consume CHDR header, short packet restarts
        ST_CHDR_IN: if (in_acc) begin
          mdata_left <= get_num_mdata(i_tdata) - 5'd1;
          if (i_tlast)
            state <= ST_CHDR_IN;
          else if (get_num_mdata(i_tdata) == 5'd0)
            state <= ST_MGMT_IN;
          else
            state <= ST_MDATA;
        end
        // Discard metadata words
        ST_MDATA: if (in_acc) begin
          mdata_left <= mdata_left - 5'd1;
          if (i_tlast)
            state <= ST_CHDR_IN;
          else if (mdata_left == 5'd0)
            state <= ST_MGMT_IN;
        end
        // Need our own hop plus at least one more
        ST_MGMT_IN: if (in_acc) begin
          if (i_tlast)
            state <= ST_CHDR_IN;
          else if (get_num_hops(i_tdata) < 10'd2)
            state <= ST_DROP;
          else
            state <= ST_EXEC;
        end
        // Decode the op word, held on the input until done
        ST_EXEC: if (i_tvalid) begin
          case (op_code)
            OP_NOP, OP_INFO_REQ, OP_INFO_RESP, OP_CFG_RD_RESP:
              state <= ST_OP_DONE;
            OP_CFG_WR_REQ, OP_CFG_RD_REQ:
              state <= ST_WAIT;
            default:
              state <= ST_DROP;
          endcase
        end
        // Control-port access outstanding
        ST_WAIT: if (i_cp_ack) state <= ST_OP_DONE;
        // Consume op word, last op of the hop starts the output
        ST_OP_DONE: if (in_acc) begin
          if (i_tlast)
            state <= ST_CHDR_IN;
          else if (ops_pending == 8'd0)
            state <= ST_CHDR_OUT;
          else
            state <= ST_EXEC;
        end
        ST_CHDR_OUT: if (out_acc) state <= ST_MGMT_OUT;
        ST_MGMT_OUT: if (out_acc) begin
          state <= (cnt.hops_left == 10'd1) ? ST_MOD_LAST : ST_PASS;
        end
        // Middle hops as-is, count hop ends
        ST_PASS: if (out_acc) begin
          if (i_tlast)
            state <= ST_CHDR_IN;
          else if (ops_pending == 8'd0 && cnt.hops_left == 10'd2)
            state <= ST_MOD_LAST;
        end
        ST_MOD_LAST: if (out_acc && (ops_pending == 8'd0 || i_tlast)) begin
          in_done <= i_tlast;
          if (resp.valid)
            state <= ST_APPEND;
          else
            state <= i_tlast ? ST_CHDR_IN : ST_DROP;
        end
        // Head was sent, drop it and look for more
        ST_POP: begin
          if (resp.count > RESP_CNT_W'(1))
            state <= ST_APPEND;
          else
            state <= in_done ? ST_CHDR_IN : ST_DROP;
        end
        ST_APPEND: if (out_acc) state <= ST_POP;
        // Flush the rest of the input packet
        ST_DROP: if (in_acc && i_tlast) state <= ST_CHDR_IN;
        default: state <= ST_CHDR_IN;
      endcase
    end
  end

  // Handshake and output select --
  always_comb begin
    o_tready_in = 1'b0;
    o_tvalid    = 1'b0;
    o_tlast_gen = 1'b0;
    o_sel       = SEL_NONE;
    case (state)
      ST_CHDR_IN, ST_MDATA, ST_MGMT_IN, ST_OP_DONE, ST_DROP: o_tready_in = 1'b1;
      ST_CHDR_OUT: begin
        o_tvalid = 1'b1;
        o_sel    = SEL_CHDR;
      end
      ST_MGMT_OUT: begin
        o_tvalid = 1'b1;
        o_sel    = SEL_MGMT;
      end
      ST_PASS: begin
        o_tready_in = i_tready_out;
        o_tvalid    = i_tvalid;
        o_tlast_gen = i_tlast;
        o_sel       = SEL_PASS;
      end
      ST_MOD_LAST: begin
        o_tready_in = i_tready_out;
        o_tvalid    = i_tvalid;
        o_tlast_gen = i_tlast && !resp.valid;
        o_sel       = SEL_MOD;
      end
      ST_APPEND: begin
        o_tvalid    = 1'b1;
        o_tlast_gen = (resp.count == RESP_CNT_W'(1));
        o_sel       = SEL_RESP;
      end
      default: o_sel = SEL_NONE;
    endcase
  end

  // Header caching and counters
  assign o_cache_chdr  = (state == ST_CHDR_IN) && in_acc;
  assign o_cache_mgmt  = (state == ST_MGMT_IN) && in_acc;
  assign cnt.load_chdr = o_cache_chdr;
  assign cnt.load_mgmt = o_cache_mgmt;
  assign cnt.in_word   = i_tdata;
  assign cnt.dec_len   = (state == ST_MDATA || state == ST_OP_DONE) && in_acc;
  assign cnt.dec_hop   = (state == ST_PASS) && out_acc && (ops_pending == 8'd0);

  // Control port, request only on the first execute cycle
  assign o_cp_wr   = (state == ST_EXEC) && i_tvalid && (op_code == OP_CFG_WR_REQ);
  assign o_cp_rd   = (state == ST_EXEC) && i_tvalid && (op_code == OP_CFG_RD_REQ);
  assign o_cp_addr = op_payload[15:0];
  assign o_cp_data = op_payload[47:16];

  // Responses: read data on ack, node info as the op word leaves
  assign resp.clear = o_cache_chdr;
  assign resp.pop   = (state == ST_POP);
  assign resp.push  = ((state == ST_WAIT) && i_cp_ack && (op_code == OP_CFG_RD_REQ)) ||
                      ((state == ST_OP_DONE) && i_tvalid && (op_code == OP_INFO_REQ));
  assign resp.push_data = (op_code == OP_CFG_RD_REQ) ?
                          {i_cp_rdata, o_cp_addr, OP_CFG_RD_RESP} :
                          {NODE_INFO, OP_INFO_RESP};

endmodule

//--- design/mgmt_hop_counter.sv
/* Tracks the packet length left after stripping and the hops still to
   forward. Driven by strobes from the management FSM. */
`timescale 1ns/1ps

module mgmt_hop_counter (
  input  logic      clk,
  input  logic      rst,
  mgmt_count_if.cnt cnt
);
  import mgmt_pkg::*;

  len_t  len_q;
  hops_t hops_q;

  // Length ------------------------
  // Header word removed at load, then one word per strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      len_q <= '0;
    end else if (cnt.load_chdr) begin
      len_q <= get_length(cnt.in_word) - WORD_BYTES;
    end else if (cnt.load_mgmt || cnt.dec_len) begin
      // Management header or a metadata/op word
      len_q <= len_q - WORD_BYTES;
    end
  end

  // Hops --------------------------
  // Own hop excluded at load
  always_ff @(posedge clk) begin
    if (rst) begin
      hops_q <= '0;
    end else if (cnt.load_mgmt) begin
      hops_q <= get_num_hops(cnt.in_word) - 10'd1;
    end else if (cnt.dec_hop) begin
      hops_q <= hops_q - 10'd1;
    end
  end

  assign cnt.stripped_len = len_q;
  assign cnt.hops_left    = hops_q;

endmodule

//--- design/mgmt_if.sv
/* Interfaces between the management FSM, the length and hop counter,
   and the response FIFO. Instantiated once each in the top level. */
`timescale 1ns/1ps

// FSM to counter strobes, counter results back
interface mgmt_count_if;
  import mgmt_pkg::*;

  logic  load_chdr;
  logic  load_mgmt;
  word_t in_word;
  logic  dec_len;
  logic  dec_hop;
  len_t  stripped_len;
  hops_t hops_left;

  modport ctl (
    output load_chdr, load_mgmt, in_word, dec_len, dec_hop,
    input  hops_left
  );

  modport cnt (
    input  load_chdr, load_mgmt, in_word, dec_len, dec_hop,
    output stripped_len, hops_left
  );
endinterface

// Response queue, single-cycle push and pop with no back-pressure
interface mgmt_resp_if;
  import mgmt_pkg::*;

  logic                  push;
  resp_t                 push_data;
  logic                  pop;
  logic                  clear;
  logic                  valid;
  resp_t                 head;
  logic [RESP_CNT_W-1:0] count;

  modport wr (
    output push, push_data, pop, clear,
    input  valid, head, count
  );

  modport fifo (
    input  push, push_data, pop, clear,
    output valid, head, count
  );

  // Read-only view for the output word builder
  modport rd (
    input valid, head, count
  );
endinterface

//--- design/mgmt_node.sv
/* Top level of the CHDR management node. Connects the FSM, the counter,
   the response FIFO and the word builder to the plain stream and control ports. */
`timescale 1ns/1ps

module mgmt_node (
  input  logic               clk,
  input  logic               rst,
  // CHDR input
  input  mgmt_pkg::word_t    i_tdata,
  input  logic               i_tlast,
  input  logic               i_tvalid,
  output logic               o_tready_in,
  // CHDR output
  output mgmt_pkg::word_t    o_tdata,
  output logic               o_tlast,
  output logic               o_tvalid,
  input  logic               i_tready_out,
  // Control port
  output logic               o_cp_wr,
  output logic               o_cp_rd,
  output mgmt_pkg::cp_addr_t o_cp_addr,
  output mgmt_pkg::cp_data_t o_cp_data,
  input  logic               i_cp_ack,
  input  mgmt_pkg::cp_data_t i_cp_rdata
);
  import mgmt_pkg::*;

  out_sel_t sel;
  logic     cache_chdr;
  logic     cache_mgmt;

  mgmt_count_if cnt_if ();
  mgmt_resp_if  resp_if ();

  // ------------------------------
  // Control path
  mgmt_fsm fsm_i (
    .clk          (clk),
    .rst          (rst),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready_in  (o_tready_in),
    .o_tvalid     (o_tvalid),
    .i_tready_out (i_tready_out),
    .o_sel        (sel),
    .o_cache_chdr (cache_chdr),
    .o_cache_mgmt (cache_mgmt),
    .o_tlast_gen  (o_tlast),
    .cnt          (cnt_if.ctl),
    .resp         (resp_if.wr),
    .o_cp_wr      (o_cp_wr),
    .o_cp_rd      (o_cp_rd),
    .o_cp_addr    (o_cp_addr),
    .o_cp_data    (o_cp_data),
    .i_cp_ack     (i_cp_ack),
    .i_cp_rdata   (i_cp_rdata)
  );

  mgmt_hop_counter cnt_i (.clk(clk), .rst(rst), .cnt(cnt_if.cnt));

  mgmt_resp_fifo resp_fifo_i (.clk(clk), .rst(rst), .resp(resp_if.fifo));

  // ------------------------------
  // Data path
  mgmt_word_builder builder_i (
    .clk            (clk),
    .i_sel          (sel),
    .i_cache_chdr   (cache_chdr),
    .i_cache_mgmt   (cache_mgmt),
    .i_tdata        (i_tdata),
    .i_stripped_len (cnt_if.stripped_len),
    .resp           (resp_if.rd),
    .o_tdata        (o_tdata)
  );

endmodule

//--- design/mgmt_pkg.sv
/* Word formats, opcodes, widths and constants for the CHDR management node.
   Every design module and interface imports what it needs from here. */
package mgmt_pkg;

  // Bus and field types ------------
  typedef logic [63:0] word_t;
  typedef logic [15:0] epid_t;
  typedef logic [15:0] len_t;
  typedef logic [9:0]  hops_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [7:0]  pending_t;
  typedef logic [47:0] payload_t;
  // Response entry is {payload, opcode}
  typedef logic [55:0] resp_t;
  typedef logic [15:0] cp_addr_t;
  typedef logic [31:0] cp_data_t;

  // Node constants -----------------
  localparam logic [15:0] PROTOVER    = 16'h0100;
  localparam logic [2:0]  CHDR_W_ENUM = 3'd0;
  localparam payload_t    NODE_INFO   = 48'h00C0FFEE1234;
  localparam len_t        WORD_BYTES  = 16'd8;
  localparam int          RESP_DEPTH  = 8;
  localparam int          RESP_CNT_W  = 4;
  localparam int          RESP_PTR_W  = $clog2(RESP_DEPTH);

  // Management opcodes
  localparam opcode_t OP_NOP         = 8'd0;
  localparam opcode_t OP_INFO_REQ    = 8'd2;
  localparam opcode_t OP_INFO_RESP   = 8'd3;
  localparam opcode_t OP_CFG_WR_REQ  = 8'd4;
  localparam opcode_t OP_CFG_RD_REQ  = 8'd5;
  localparam opcode_t OP_CFG_RD_RESP = 8'd6;

  // Source of each output word
  typedef enum logic [2:0] {
    SEL_NONE, SEL_CHDR, SEL_MGMT, SEL_PASS, SEL_MOD, SEL_RESP
  } out_sel_t;

  typedef enum logic [3:0] {
    ST_CHDR_IN, ST_MDATA, ST_MGMT_IN, ST_EXEC, ST_WAIT, ST_OP_DONE,
    ST_CHDR_OUT, ST_MGMT_OUT, ST_PASS, ST_MOD_LAST, ST_POP, ST_APPEND, ST_DROP
  } pkt_state_t;

  // Field access -------------------
  // CHDR header
  function automatic len_t get_length(word_t w);
    return w[31:16];
  endfunction

  function automatic logic [4:0] get_num_mdata(word_t w);
    return w[36:32];
  endfunction

  // Management header
  function automatic hops_t get_num_hops(word_t w);
    return w[25:16];
  endfunction

  // Operation word
  function automatic pending_t get_ops_pending(word_t w);
    return w[7:0];
  endfunction

  function automatic opcode_t get_opcode(word_t w);
    return w[15:8];
  endfunction

  function automatic payload_t get_payload(word_t w);
    return w[63:16];
  endfunction

  function automatic word_t build_op(payload_t pl, opcode_t op, pending_t pend);
    return {pl, op, pend};
  endfunction

endpackage

//--- design/mgmt_resp_fifo.sv
/* Circular queue of pending responses with its occupancy count.
   Cleared by the FSM at the start of each packet, full pushes are lost. */
`timescale 1ns/1ps

module mgmt_resp_fifo (
  input  logic       clk,
  input  logic       rst,
  mgmt_resp_if.fifo  resp
);
  import mgmt_pkg::*;

  resp_t                 mem [RESP_DEPTH];
  logic [RESP_PTR_W-1:0] wr_ptr;
  logic [RESP_PTR_W-1:0] rd_ptr;
  logic [RESP_CNT_W-1:0] cnt_q;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = resp.push && (cnt_q != RESP_CNT_W'(RESP_DEPTH));
  assign do_pop  = resp.pop && (cnt_q != '0);

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= resp.push_data;
  end

  // Pointers and count ------------
  always_ff @(posedge clk) begin
    if (rst || resp.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop)
        cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  assign resp.valid = (cnt_q != '0);
  assign resp.head  = mem[rd_ptr];
  assign resp.count = cnt_q;

endmodule

//--- design/mgmt_word_builder.sv
/* Caches the input CHDR and management headers and forms each output
   word from the select code given by the FSM. */
`timescale 1ns/1ps

module mgmt_word_builder (
  input  logic               clk,
  input  mgmt_pkg::out_sel_t i_sel,
  input  logic               i_cache_chdr,
  input  logic               i_cache_mgmt,
  input  mgmt_pkg::word_t    i_tdata,
  input  mgmt_pkg::len_t     i_stripped_len,
  mgmt_resp_if.rd            resp,
  output mgmt_pkg::word_t    o_tdata
);
  import mgmt_pkg::*;

  word_t chdr_q;
  word_t mgmt_q;
  len_t  out_len;
  hops_t out_hops;

  // Header cache
  always_ff @(posedge clk) begin
    if (i_cache_chdr) chdr_q <= i_tdata;
    if (i_cache_mgmt) mgmt_q <= i_tdata;
  end

  // Length grows by one word per queued response
  assign out_len  = i_stripped_len + len_t'(resp.count) * WORD_BYTES;
  assign out_hops = get_num_hops(mgmt_q) - 10'd1;

  // Output word mux ---------------
  always_comb begin
    case (i_sel)
      // Metadata removed, dst_epid and upper bits kept
      SEL_CHDR: o_tdata = {chdr_q[63:37], 5'd0, out_len, chdr_q[15:0]};
      // Fresh protocol fields, src_epid kept
      SEL_MGMT: o_tdata = {PROTOVER, CHDR_W_ENUM, 19'd0, out_hops, mgmt_q[15:0]};
      SEL_PASS: o_tdata = i_tdata;
      // Last-hop ops count the appended responses too
      SEL_MOD: o_tdata = build_op(get_payload(i_tdata), get_opcode(i_tdata),
                                  get_ops_pending(i_tdata) + pending_t'(resp.count));
      SEL_RESP: o_tdata = build_op(resp.head[55:8], resp.head[7:0],
                                   pending_t'(resp.count - 1'b1));
      default: o_tdata = '0;
    endcase
  end

endmodule
